// ==== bench/crc_input_vectors.txt ====
# cmd addr size data expected; W and R take 0 to 3 idle cycles first, w and r follow at once
# size is HSIZE (0 byte, 1 halfword, 2 word); expected applies to reads, CR reads compare bits 7:3
R 10 2 00000000 FFFFFFFF
R 14 2 00000000 04C11DB7
R 08 2 00000000 00000000
R 04 2 00000000 00000000
R 00 2 00000000 FFFFFFFF
W 04 2 123456A5 00000000
R 04 2 00000000 000000A5
W 10 2 A5A55A5A 00000000
R 10 2 00000000 A5A55A5A
W 14 2 DEADBEEF 00000000
R 14 2 00000000 DEADBEEF
W 14 2 04C11DB7 00000000
W 10 2 FFFFFFFF 00000000
W 08 2 00000001 00000000
R 08 2 00000000 00000000
# CRC-32 by word, second and fourth words cancel the running value
W 00 2 12345678 00000000
R 00 2 00000000 DF8A8A2B
W 00 2 DF8A8A2B 00000000
R 00 2 00000000 00000000
W 00 2 EDCBA987 00000000
W 00 2 324123AC 00000000
R 00 2 00000000 DF8A8A2B
# Same data as bytes, then as halfwords
W 08 2 00000001 00000000
W 00 0 00000012 00000000
R 00 2 00000000 0B9B5FAA
W 00 0 00000034 00000000
R 00 2 00000000 77227A2D
W 00 0 00000056 00000000
W 00 0 00000078 00000000
R 00 2 00000000 DF8A8A2B
W 08 2 00000001 00000000
W 00 1 00001234 00000000
W 00 1 00005678 00000000
R 00 2 00000000 DF8A8A2B
# 16-bit poly 1021, INIT FFFF, "123456789"
W 14 2 00001021 00000000
W 08 2 00000009 00000000
R 08 2 00000000 00000008
W 00 1 00003132 00000000
W 00 1 00003334 00000000
W 00 1 00003536 00000000
W 00 1 00003738 00000000
W 00 0 00000039 00000000
R 00 2 00000000 000029B1
# 8-bit poly 07, INIT 0
W 14 2 00000007 00000000
W 10 2 00000000 00000000
W 08 2 00000011 00000000
R 08 2 00000000 00000010
W 00 2 31323334 00000000
W 00 2 35363738 00000000
W 00 0 00000039 00000000
R 00 2 00000000 000000F4
# 7-bit poly 09, INIT 0
W 14 2 00000009 00000000
W 08 2 00000019 00000000
R 08 2 00000000 00000018
W 00 0 00000031 00000000
W 00 1 00003233 00000000
W 00 2 34353637 00000000
W 00 1 00003839 00000000
R 00 2 00000000 00000075
# Input reversal by byte, halfword, word, all with output reversal
W 14 2 04C11DB7 00000000
W 10 2 FFFFFFFF 00000000
W 08 2 000000A1 00000000
R 08 2 00000000 000000A0
W 00 2 31323334 00000000
W 00 2 35363738 00000000
W 00 0 00000039 00000000
R 00 2 00000000 340BC6D9
W 08 2 000000C1 00000000
R 08 2 00000000 000000C0
W 00 1 00003231 00000000
W 00 1 00003433 00000000
W 00 1 00003635 00000000
W 00 1 00003837 00000000
W 00 0 00000039 00000000
R 00 2 00000000 340BC6D9
W 08 2 000000E1 00000000
R 08 2 00000000 000000E0
W 00 2 34333231 00000000
W 00 1 00003635 00000000
W 00 1 00003837 00000000
W 00 0 00000039 00000000
R 00 2 00000000 340BC6D9
W 08 2 00000081 00000000
R 08 2 00000000 00000080
W 00 2 12345678 00000000
R 00 2 00000000 D45151FB
# Back-to-back DR writes, then a read at once
W 08 2 00000001 00000000
W 00 2 12345678 00000000
w 00 2 DF8A8A2B 00000000
w 00 2 EDCBA987 00000000
w 00 2 324123AC 00000000
r 00 2 00000000 DF8A8A2B
# Chain reset while busy, INIT write waits for it
W 00 2 12345678 00000000
w 08 2 00000001 00000000
w 10 2 00000000 00000000
w 00 2 EDCBA987 00000000
r 00 2 00000000 DF8A8A2B
R 10 2 00000000 00000000

// ==== include/crc_tb_checks.svh ====
`ifndef CRC_TB_CHECKS_SVH
`define CRC_TB_CHECKS_SVH

////////////////////
// AHB bus tasks
////////////////////

// Entered 2 ns after a rising edge, returns at the falling edge with HREADYOUT high
task automatic wait_data_phase(input logic [31:0] addr);
	int stall;
	stall = 0;
	// HREADYOUT is stable at the falling edge
	@(negedge HCLK);
	while (!HREADYOUT)
	begin
		stall++;
		if (stall == 65)
		begin
			bus_errors++;
			$display("Bus stalled for more than 64 cycles at %0t, address %h", $time, addr);
		end
		@(negedge HCLK);
	end
endtask

// Called 2 ns after a rising edge, returns the same way
task automatic ahb_write(input logic [31:0] addr, input logic [2:0] size,
		input logic [31:0] data);
	HSEL   = 1'b1;
	HADDR  = addr;
	HTRANS = crc_pkg::NONSEQ;
	HWRITE = 1'b1;
	HSIZE  = size;
	@(posedge HCLK);
	#2;
	HSEL   = 1'b0;
	HTRANS = crc_pkg::IDLE;
	HWRITE = 1'b0;
	HWDATA = data;
	wait_data_phase(addr);
	check_resp(addr, 1'b0, HRESP, bus_errors);
	@(posedge HCLK);
	#2;
endtask

task automatic ahb_read(input logic [31:0] addr, input logic [2:0] size,
		output logic [31:0] data);
	HSEL   = 1'b1;
	HADDR  = addr;
	HTRANS = crc_pkg::NONSEQ;
	HWRITE = 1'b0;
	HSIZE  = size;
	@(posedge HCLK);
	#2;
	HSEL   = 1'b0;
	HTRANS = crc_pkg::IDLE;
	wait_data_phase(addr);
	// Sampled just ahead of the completing edge
	data = HRDATA;
	check_resp(addr, 1'b0, HRESP, bus_errors);
	@(posedge HCLK);
	#2;
endtask

////////////////////
// Compare tasks
////////////////////

task automatic check_data(input logic [31:0] addr, input logic [31:0] exp,
		input logic [31:0] act, inout int errors);
	if (act !== exp)
	begin
		errors++;
		$display("[FAIL] %0t addr %h expected %h actual %h", $time, addr, exp, act);
	end
endtask

// CR fields as read back from HRDATA[7:3]
task automatic check_cfg(input logic [31:0] addr, input crc_pkg::crc_cfg_t exp,
		input crc_pkg::crc_cfg_t act, inout int errors);
	if (act !== exp)
	begin
		errors++;
		$display("[FAIL] %0t addr %h expected size %0d rev_in %0d rev_out %0d",
			$time, addr, exp.poly_size, exp.rev_in, exp.rev_out);
		$display("[FAIL] %0t addr %h actual size %0d rev_in %0d rev_out %0d",
			$time, addr, act.poly_size, act.rev_in, act.rev_out);
	end
endtask

// Transfer response at the end of the data phase
task automatic check_resp(input logic [31:0] addr, input logic exp,
		input logic act, inout int errors);
	if (act !== exp)
	begin
		errors++;
		$display("[FAIL] %0t addr %h expected HRESP %b actual %b", $time, addr, exp, act);
	end
endtask

`endif

// ==== bench/tb_crc_ahb.sv ====
module tb_crc_ahb;
	timeunit 1ns;
	timeprecision 1ps;

	import crc_pkg::*;

	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 10;
	localparam int VEC_CYCLES   = 80;

	// DUT ports
	logic        HCLK;
	logic        HRESETn;
	logic        HSEL;
	logic [31:0] HADDR;
	htrans_e     HTRANS;
	logic [2:0]  HSIZE;
	logic        HWRITE;
	logic [31:0] HWDATA;
	logic        HREADY;
	logic [31:0] HRDATA;
	logic        HREADYOUT;
	logic        HRESP;

	// Vector table, one entry per file line
	logic [7:0]  vec_cmd[$];
	logic [31:0] vec_addr[$];
	logic [31:0] vec_size[$];
	logic [31:0] vec_data[$];
	logic [31:0] vec_exp[$];

	int data_errors;
	int cfg_errors;
	int bus_errors;
	int file_errors;
	int stall_cycles;
	int seed;
	bit vectors_ready;

	`include "crc_tb_checks.svh"

	// Single slave, so the bus ready is the slave's own
	assign HREADY = HREADYOUT;

	crc_ahb_top u_crc_ahb_top (.*);

	initial
	begin
		HCLK = 1'b0;
		forever #(CLK_PERIOD / 2) HCLK = ~HCLK;
	end

	// Stall cycles seen on the bus
	always @(negedge HCLK)
	begin
		if (HRESETn && !HREADYOUT)
			stall_cycles++;
	end

	////////////////////
	// Vector file
	////////////////////

	task automatic load_vectors(output bit ok);
		int          fd;
		int          n;
		string       line;
		logic [7:0]  cmd;
		logic [31:0] addr;
		logic [31:0] size;
		logic [31:0] data;
		logic [31:0] exp;
		fd = $fopen("bench/crc_input_vectors.txt", "r");
		ok = (fd != 0);
		if (ok)
		begin
			while (!$feof(fd))
			begin
				line = "";
				n = $fgets(line, fd);
				// Skip blank and comment lines
				if ((n > 0) && (line[0] != "#") && (line[0] != "\n"))
				begin
					n = $sscanf(line, "%c %h %h %h %h", cmd, addr, size, data, exp);
					if (n != 5)
					begin
						file_errors++;
						$display("Vector line could not be parsed: %s", line);
					end
					else
					begin
						vec_cmd.push_back(cmd);
						vec_addr.push_back(addr);
						vec_size.push_back(size);
						vec_data.push_back(data);
						vec_exp.push_back(exp);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// One bus command with its check
	task automatic run_vector(input int i);
		logic [31:0] rdata;
		logic [7:0]  cmd;
		cmd = vec_cmd[i];
		if ((cmd == "W") || (cmd == "w"))
			ahb_write(vec_addr[i], vec_size[i][2:0], vec_data[i]);
		else if ((cmd == "R") || (cmd == "r"))
		begin
			ahb_read(vec_addr[i], vec_size[i][2:0], rdata);
			// CR reads compare the config fields only
			if (vec_addr[i][4:2] == CRC_CR)
				check_cfg(vec_addr[i], crc_cfg_t'(vec_exp[i][7:3]),
					crc_cfg_t'(rdata[7:3]), cfg_errors);
			else
				check_data(vec_addr[i], vec_exp[i], rdata, data_errors);
		end
		else
		begin
			file_errors++;
			$display("Unknown command %c in vector %0d", cmd, i);
		end
	endtask

	////////////////////
	// Main sequence
	////////////////////

	initial
	begin
		bit ok;
		int gap;
		HRESETn = 1'b0;
		HSEL    = 1'b0;
		HADDR   = 32'h0;
		HTRANS  = IDLE;
		HSIZE   = 3'd2;
		HWRITE  = 1'b0;
		HWDATA  = 32'h0;
		seed    = 74893;
		load_vectors(ok);
		vectors_ready = 1'b1;
		if (!ok)
		begin
			$display("Cannot open the vector file bench/crc_input_vectors.txt");
			$display("Something failed");
			$finish;
		end
		else
		begin
			repeat (RESET_CYCLES) @(posedge HCLK);
			#2;
			HRESETn = 1'b1;
			for (int i = 0; i < vec_cmd.size(); i++)
			begin
				// Upper case commands get a random idle gap
				if ((vec_cmd[i] == "W") || (vec_cmd[i] == "R"))
				begin
					gap = $random(seed) & 3;
					repeat (gap)
					begin
						@(posedge HCLK);
						#2;
					end
				end
				run_vector(i);
			end
			// DR reads right behind DR writes must have waited
			if (stall_cycles == 0)
			begin
				bus_errors++;
				$display("No HREADYOUT stall was seen during the run");
			end
			$display("Errors: data %0d, config %0d, bus %0d, file %0d (stall cycles seen %0d)",
				data_errors, cfg_errors, bus_errors, file_errors, stall_cycles);
			if ((data_errors + cfg_errors + bus_errors + file_errors) == 0)
				$display("Everything OK");
			else
				$display("Something failed");
			$finish;
		end
	end

	// Watchdog sized from the vector count
	initial
	begin
		wait (vectors_ready);
		#((RESET_CYCLES + vec_cmd.size() * VEC_CYCLES) * CLK_PERIOD);
		$display("Timeout, the run did not finish within %0d vectors of cycles",
			vec_cmd.size());
		$display("Something failed");
		$finish;
	end

endmodule

// ==== rtl/byte_counter.sv ====
module byte_counter
(
	input  logic                HCLK,
	input  logic                HRESETn,
	input  logic                load,
	input  logic                step,
	input  crc_pkg::buf_entry_t entry,
	output logic                last_byte,
	output logic [7:0]          byte_sel
);
	import crc_pkg::*;

	logic [2:0]  count;
	logic [2:0]  count_init;
	logic [31:0] shift_q;
	logic [31:0] aligned;

	// Move the valid bytes to the top so the MSB byte leaves first
	always_comb
	begin
		case (entry.size)
			SIZE_BYTE:
			begin
				aligned    = {entry.data[7:0], 24'h0};
				count_init = 3'd1;
			end
			SIZE_HALF:
			begin
				aligned    = {entry.data[15:0], 16'h0};
				count_init = 3'd2;
			end
			default:
			begin
				aligned    = entry.data;
				count_init = 3'd4;
			end
		endcase
	end

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			count <= 3'd0;
		else if (load)
			count <= count_init;
		else if (step && (count != 3'd0))
			count <= count - 3'd1;
	end

	always_ff @(posedge HCLK)
	begin
		if (load)
			shift_q <= aligned;
		else if (step)
			shift_q <= shift_q << 8;
	end

	assign byte_sel  = shift_q[31:24];
	assign last_byte = (count == 3'd1);

endmodule

// ==== rtl/crc_ahb_top.sv ====
module crc_ahb_top
(
	input  logic             HCLK,
	input  logic             HRESETn,
	input  logic             HSEL,
	input  logic [31:0]      HADDR,
	input  crc_pkg::htrans_e HTRANS,
	input  logic [2:0]       HSIZE,
	input  logic             HWRITE,
	input  logic [31:0]      HWDATA,
	input  logic             HREADY,
	output logic [31:0]      HRDATA,
	output logic             HREADYOUT,
	output logic             HRESP
);
	import crc_pkg::*;

	// Host side
	logic       buf_wr;
	buf_entry_t buf_entry;
	reg_wr_t    reg_wr;
	crc_cfg_t   cfg;
	logic       reset_chain;

	// Status back to the host
	logic        buffer_full;
	logic        read_wait;
	logic        reset_pending;
	logic [31:0] crc_out;
	logic [31:0] crc_init_out;
	logic [31:0] crc_poly_out;
	logic [7:0]  crc_idr_out;

	// Processing chain
	buf_entry_t entry;
	logic       buf_pop;
	logic       load;
	logic       step;
	logic       crc_step;
	logic       crc_reload;
	logic       last_byte;
	logic [7:0] byte_sel;

	////////////////////
	// Blocks
	////////////////////

	host_interface u_host_interface (.*);

	crc_control_fsm u_crc_control_fsm (.*);

	data_buffer u_data_buffer (.*);

	byte_counter u_byte_counter (.*);

	crc_unit u_crc_unit (.*);

endmodule

// ==== rtl/crc_control_fsm.sv ====
module crc_control_fsm
(
	input  logic HCLK,
	input  logic HRESETn,
	input  logic buffer_full,
	input  logic last_byte,
	input  logic reset_chain,
	output logic buf_pop,
	output logic load,
	output logic step,
	output logic crc_step,
	output logic crc_reload,
	output logic read_wait,
	output logic reset_pending
);
	import crc_pkg::*;

	crc_state_e state;
	crc_state_e next_state;
	logic       reset_req;

	// New request or one left over from a busy period
	assign reset_req = reset_chain || reset_pending;

	always_comb
	begin
		next_state = state;
		case (state)
			// Buffered data goes first, reset only with nothing in flight
			ST_IDLE, ST_RESET:
			begin
				if (buffer_full)
					next_state = ST_LOAD;
				else if (reset_req)
					next_state = ST_RESET;
				else
					next_state = ST_IDLE;
			end
			// ST_LOAD is the first byte after a pop
			ST_LOAD, ST_CALC:
			begin
				if (!last_byte)
					next_state = ST_CALC;
				else if (buffer_full)
					next_state = ST_LOAD;
				else
					next_state = ST_IDLE;
			end
			default: next_state = ST_IDLE;
		endcase
	end

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			state <= ST_IDLE;
		else
			state <= next_state;
	end

	// Pop, load and reload happen on the edge that enters the state
	assign buf_pop    = (next_state == ST_LOAD);
	assign load       = (next_state == ST_LOAD);
	assign crc_reload = (next_state == ST_RESET);

	// One byte per clock while processing
	assign step      = (state == ST_LOAD) || (state == ST_CALC);
	assign crc_step  = (state == ST_LOAD) || (state == ST_CALC);
	assign read_wait = buffer_full || step;

	// Pending flag clears on the reload edge
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			reset_pending <= 1'b0;
		else if (crc_reload)
			reset_pending <= 1'b0;
		else if (reset_chain)
			reset_pending <= 1'b1;
	end

endmodule

// ==== rtl/crc_pkg.sv ====
package crc_pkg;

	////////////////////
	// Bus encodings
	////////////////////

	// AHB transfer type
	typedef enum logic [1:0]
	{
		IDLE   = 2'b00,
		BUSY   = 2'b01,
		NONSEQ = 2'b10,
		SEQ    = 2'b11
	} htrans_e;

	// Register index from HADDR[4:2]
	typedef enum logic [2:0]
	{
		CRC_DR   = 3'h0,
		CRC_IDR  = 3'h1,
		CRC_CR   = 3'h2,
		CRC_INIT = 3'h4,
		CRC_POL  = 3'h5
	} crc_reg_e;

	// Same coding as HSIZE[1:0]
	typedef enum logic [1:0]
	{
		SIZE_BYTE = 2'b00,
		SIZE_HALF = 2'b01,
		SIZE_WORD = 2'b10
	} bus_size_e;

	////////////////////
	// CRC configuration
	////////////////////

	typedef enum logic [1:0] {POLY_32, POLY_16, POLY_8, POLY_7} poly_size_e;

	typedef enum logic [1:0] {REV_NONE, REV_BYTE, REV_HALF, REV_WORD} rev_in_e;

	typedef enum logic [1:0] {ST_IDLE, ST_LOAD, ST_CALC, ST_RESET} crc_state_e;

	// CR fields, HWDATA[7:3] order
	typedef struct packed
	{
		logic       rev_out;
		rev_in_e    rev_in;
		poly_size_e poly_size;
	} crc_cfg_t;

	// One DR write as held in the buffer
	typedef struct packed
	{
		logic [31:0] data;
		bus_size_e   size;
	} buf_entry_t;

	// Register write strobes with shared write data
	typedef struct packed
	{
		logic        init;
		logic        idr;
		logic        poly;
		logic [31:0] wdata;
	} reg_wr_t;

	localparam crc_cfg_t    CRC_CR_RESET   = '0;
	localparam logic [31:0] CRC_INIT_RESET = 32'hFFFF_FFFF;
	localparam logic [31:0] CRC_POL_RESET  = 32'h04C1_1DB7;
	localparam logic        HRESP_OKAY     = 1'b0;

endpackage

// ==== rtl/crc_unit.sv ====
module crc_unit
(
	input  logic              HCLK,
	input  logic              HRESETn,
	input  crc_pkg::reg_wr_t  reg_wr,
	input  crc_pkg::crc_cfg_t cfg,
	input  logic [7:0]        byte_sel,
	input  logic              crc_step,
	input  logic              crc_reload,
	output logic [31:0]       crc_out,
	output logic [31:0]       crc_init_out,
	output logic [31:0]       crc_poly_out,
	output logic [7:0]        crc_idr_out
);
	import crc_pkg::*;

	logic [31:0] crc_q;
	logic [31:0] crc_next;
	logic [31:0] crc_masked;
	logic [31:0] width_mask;
	logic [31:0] top_bit;

	// Eight serial steps, MSB of the byte first
	function automatic logic [31:0] crc_byte
	(
		input logic [31:0] crc,
		input logic [7:0]  data,
		input logic [31:0] poly,
		input logic [31:0] mask,
		input logic [31:0] top
	);
		logic [31:0] c;
		logic        fb;
		c = crc;
		for (int b = 7; b >= 0; b--)
		begin
			fb = ((c & top) != 32'h0) ^ data[b];
			c  = (c << 1) & mask;
			if (fb)
				c = c ^ (poly & mask);
		end
		return c;
	endfunction

	// Width mask and feedback tap for N = 32, 16, 8, 7
	always_comb
	begin
		case (cfg.poly_size)
			POLY_32:
			begin
				width_mask = 32'hFFFF_FFFF;
				top_bit    = 32'h8000_0000;
			end
			POLY_16:
			begin
				width_mask = 32'h0000_FFFF;
				top_bit    = 32'h0000_8000;
			end
			POLY_8:
			begin
				width_mask = 32'h0000_00FF;
				top_bit    = 32'h0000_0080;
			end
			default:
			begin
				width_mask = 32'h0000_007F;
				top_bit    = 32'h0000_0040;
			end
		endcase
	end

	assign crc_next = crc_byte(crc_q, byte_sel, crc_poly_out, width_mask, top_bit);

	////////////////////
	// Registers
	////////////////////

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			crc_init_out <= CRC_INIT_RESET;
			crc_poly_out <= CRC_POL_RESET;
			crc_idr_out  <= 8'h0;
		end
		else
		begin
			if (reg_wr.init)
				crc_init_out <= reg_wr.wdata;
			if (reg_wr.poly)
				crc_poly_out <= reg_wr.wdata;
			if (reg_wr.idr)
				crc_idr_out <= reg_wr.wdata[7:0];
		end
	end

	// Chain reset first, then INIT write seeds the CRC, then data
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			crc_q <= CRC_INIT_RESET;
		else if (crc_reload)
			crc_q <= crc_init_out;
		else if (reg_wr.init)
			crc_q <= reg_wr.wdata;
		else if (crc_step)
			crc_q <= crc_next;
	end

	// Result masked to N bits, then optionally flipped end to end
	assign crc_masked = crc_q & width_mask;

	always_comb
	begin
		if (cfg.rev_out)
			crc_out = {<<{crc_masked}};
		else
			crc_out = crc_masked;
	end

endmodule

// ==== rtl/data_buffer.sv ====
module data_buffer
(
	input  logic                HCLK,
	input  logic                HRESETn,
	input  logic                buf_wr,
	input  crc_pkg::buf_entry_t buf_entry,
	input  logic                buf_pop,
	input  crc_pkg::crc_cfg_t   cfg,
	output logic                buffer_full,
	output crc_pkg::buf_entry_t entry
);
	import crc_pkg::*;

	logic [1:0]  mode_span;
	logic [1:0]  span;
	logic [31:0] rev_data;

	// Bit reversal inside each chunk of w bits
	function automatic logic [31:0] rev_chunks(input logic [31:0] d, input int w);
		logic [31:0] r;
		for (int i = 0; i < 32; i++)
			r[(i / w) * w + w - 1 - i % w] = d[i];
		return r;
	endfunction

	// Span 0 byte, 1 halfword, 2 word; never wider than the transfer
	assign mode_span = cfg.rev_in - 2'd1;
	assign span      = (mode_span < buf_entry.size) ? mode_span : buf_entry.size;

	always_comb
	begin
		rev_data = buf_entry.data;
		if (cfg.rev_in != REV_NONE)
		begin
			case (span)
				2'd0:    rev_data = rev_chunks(buf_entry.data, 8);
				2'd1:    rev_data = rev_chunks(buf_entry.data, 16);
				default: rev_data = rev_chunks(buf_entry.data, 32);
			endcase
		end
	end

	// Single entry, write and pop never in the same cycle
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			buffer_full <= 1'b0;
		else if (buf_wr)
			buffer_full <= 1'b1;
		else if (buf_pop)
			buffer_full <= 1'b0;
	end

	always_ff @(posedge HCLK)
	begin
		if (buf_wr)
		begin
			entry.data <= rev_data;
			entry.size <= buf_entry.size;
		end
	end

endmodule

// ==== rtl/host_interface.sv ====
module host_interface
(
	input  logic                HCLK,
	input  logic                HRESETn,
	input  logic                HSEL,
	input  logic [31:0]         HADDR,
	input  crc_pkg::htrans_e    HTRANS,
	input  logic [2:0]          HSIZE,
	input  logic                HWRITE,
	input  logic [31:0]         HWDATA,
	input  logic                HREADY,
	input  logic                buffer_full,
	input  logic                read_wait,
	input  logic                reset_pending,
	input  logic [31:0]         crc_out,
	input  logic [31:0]         crc_init_out,
	input  logic [31:0]         crc_poly_out,
	input  logic [7:0]          crc_idr_out,
	output logic [31:0]         HRDATA,
	output logic                HREADYOUT,
	output logic                HRESP,
	output logic                buf_wr,
	output crc_pkg::buf_entry_t buf_entry,
	output crc_pkg::reg_wr_t    reg_wr,
	output crc_pkg::crc_cfg_t   cfg,
	output logic                reset_chain
);
	import crc_pkg::*;

	// Data phase copies of the address phase
	logic      hsel_pp;
	htrans_e   htrans_pp;
	logic      hwrite_pp;
	crc_reg_e  haddr_pp;
	bus_size_e hsize_pp;

	logic sample_bus;
	logic write_en;
	logic read_en;
	logic dr_wr;
	logic dr_rd;
	logic init_wr;
	logic cr_wr;

	// Address phase taken when the previous data phase ends
	assign sample_bus = HREADY && HREADYOUT;

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			hsel_pp   <= 1'b0;
			htrans_pp <= IDLE;
		end
		else if (sample_bus)
		begin
			hsel_pp   <= HSEL;
			htrans_pp <= HTRANS;
		end
	end

	always_ff @(posedge HCLK)
	begin
		if (sample_bus)
		begin
			hwrite_pp <= HWRITE;
			haddr_pp  <= crc_reg_e'(HADDR[4:2]);
			hsize_pp  <= bus_size_e'(HSIZE[1:0]);
		end
	end

	////////////////////
	// Decode
	////////////////////

	// SEQ and BUSY are ignored
	assign write_en = hsel_pp && hwrite_pp && (htrans_pp == NONSEQ);
	assign read_en  = hsel_pp && !hwrite_pp && (htrans_pp == NONSEQ);

	assign dr_wr   = write_en && (haddr_pp == CRC_DR);
	assign dr_rd   = read_en && (haddr_pp == CRC_DR);
	assign init_wr = write_en && (haddr_pp == CRC_INIT);
	assign cr_wr   = write_en && (haddr_pp == CRC_CR);

	// Stall on full buffer, busy read, or INIT behind a pending reset
	assign HREADYOUT = !((dr_wr && buffer_full) ||
	                     (dr_rd && read_wait) ||
	                     (init_wr && reset_pending));

	assign HRESP = HRESP_OKAY;

	// Buffer takes the word only in the cycle the write completes
	assign buf_wr = dr_wr && !buffer_full;

	always_comb
	begin
		buf_entry.data = HWDATA;
		buf_entry.size = hsize_pp;
		reg_wr.init    = init_wr && !reset_pending;
		reg_wr.idr     = write_en && (haddr_pp == CRC_IDR);
		reg_wr.poly    = write_en && (haddr_pp == CRC_POL);
		reg_wr.wdata   = HWDATA;
	end

	// CR holds bits 7:3; bit 0 is a self-clearing reset request
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			cfg <= CRC_CR_RESET;
		else if (cr_wr)
			cfg <= crc_cfg_t'(HWDATA[7:3]);
	end

	assign reset_chain = cr_wr && HWDATA[0];

	// Read data by register
	always_comb
	begin
		case (haddr_pp)
			CRC_DR:   HRDATA = crc_out;
			CRC_IDR:  HRDATA = {24'h0, crc_idr_out};
			CRC_CR:   HRDATA = {24'h0, cfg, 3'h0};
			CRC_INIT: HRDATA = crc_init_out;
			CRC_POL:  HRDATA = crc_poly_out;
			default:  HRDATA = 32'h0;
		endcase
	end

endmodule

// ==== sim.f ====
+incdir+include
rtl/crc_pkg.sv
rtl/host_interface.sv
rtl/crc_control_fsm.sv
rtl/byte_counter.sv
rtl/data_buffer.sv
rtl/crc_unit.sv
rtl/crc_ahb_top.sv
bench/tb_crc_ahb.sv
